//--- Makefile
# Verilator build for the ROM message beacon
# Any variable can be set on the command line, e.g. make OBJDIR=build

VERILATOR ?= verilator
TOP       ?= romUartTb
FILELIST  ?= romUartTx.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_TEXT ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Output goes to the terminal and the exit status comes from the search
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- hw/messageRom.sv
/*
 * Message ROM with one registered read port.
 * Contents are unpacked from the package message text at elaboration,
 * so entry 0 holds the first character on the line.
 */
module messageRom
    import uartPkg::*;
(
    input  logic              Enable,
    input  logic              arstN,
    input  logic              rdEn,      // Read strobe from the driver
    input  logic [ADDR_W-1:0] addr,
    output logic [7:0]        rdData     // Valid one cycle after rdEn
);

    logic [7:0] romMem [MSG_LEN];

    // Byte i of the text sits counted down from the top of the literal
    for (genvar i = 0; i < MSG_LEN; i++) begin : gRomFill
        assign romMem[i] = MSG_TEXT[8*(MSG_LEN-1-i) +: 8];
    end

    // Output register holds its value between strobes
    always_ff @(posedge Enable or negedge arstN) begin
        if (!arstN) begin
            rdData <= '0;
        end else if (rdEn) begin
            rdData <= romMem[addr];     // Every address maps to an entry
        end
    end

endmodule

//--- hw/romUartTop.sv
/*
 * Top level of the ROM message beacon.
 * Joins the configuration registers, message ROM, sequencer and
 * UART serializer.
 */
module romUartTop
    import uartPkg::*;
(
    input  logic      Enable,
    input  logic      arstN,
    input  logic      cfgValid,
    output logic      cfgReady,
    input  cfgWrite_t cfgReq,
    output logic      txd,
    output logic      msgDone
);

    txCfg_t            cfg;
    logic              busy;
    logic              rdEn;
    logic [ADDR_W-1:0] romAddr;
    logic [7:0]        romData;
    logic              byteValid;
    logic              byteReady;
    txByte_t           byteData;
    logic              frameDone;

    txConfig u_txConfig (
        .Enable(Enable), .arstN(arstN), .cfgValid(cfgValid), .cfgReady(cfgReady),
        .cfgReq(cfgReq), .busy(busy), .cfg(cfg)
    );

    messageRom u_messageRom (
        .Enable(Enable), .arstN(arstN), .rdEn(rdEn), .addr(romAddr), .rdData(romData)
    );

    // Sequencer sits between the ROM and the serializer
    txDriver u_txDriver (
        .Enable(Enable), .arstN(arstN), .cfg(cfg), .rdEn(rdEn), .addr(romAddr),
        .rdData(romData), .byteValid(byteValid), .byteReady(byteReady),
        .byteData(byteData), .frameDone(frameDone), .busy(busy), .msgDone(msgDone)
    );

    uartTx u_uartTx (
        .Enable(Enable), .arstN(arstN), .baudDiv(cfg.baudDiv), .byteValid(byteValid),
        .byteReady(byteReady), .byteData(byteData), .txd(txd), .frameDone(frameDone)
    );

endmodule

//--- hw/txConfig.sv
/*
 * Configuration registers for the beacon.
 * A valid/ready write port sets baud divisor, message length, gap and
 * run bit, clamps values into their legal range and stalls while a
 * message is in flight.
 */
module txConfig
    import uartPkg::*;
(
    input  logic      Enable,
    input  logic      arstN,
    input  logic      cfgValid,
    output logic      cfgReady,
    input  cfgWrite_t cfgReq,
    input  logic      busy,         // Driver is in the middle of a message
    output txCfg_t    cfg
);

    logic             wrEn;
    logic [15:0]      baudClamp;
    logic [LEN_W-1:0] lenClamp;

    assign cfgReady = !busy;                    // Writes wait for the message to end
    assign wrEn     = cfgValid && cfgReady;

    // Baud divisor below 2 would leave no room for the bit counter
    always_comb begin
        if (cfgReq.data < BAUD_DIV_MIN) baudClamp = BAUD_DIV_MIN;
        else baudClamp = cfgReq.data;
    end

    // Length is pulled into 1 to MSG_LEN
    always_comb begin
        if (cfgReq.data == 16'd0) begin
            lenClamp = LEN_W'(1);
        end else if (cfgReq.data > 16'(MSG_LEN)) begin
            lenClamp = LEN_MAX;                 // Longer than the ROM holds
        end else begin
            lenClamp = cfgReq.data[LEN_W-1:0];
        end
    end

    always_ff @(posedge Enable or negedge arstN) begin
        if (!arstN) begin
            cfg <= CFG_RESET;                   // Run comes up clear
        end else if (wrEn) begin
            case (cfgReq.addr)
                REG_BAUD: cfg.baudDiv <= baudClamp;
                REG_LEN:  cfg.msgLen  <= lenClamp;
                REG_GAP:  cfg.gap     <= cfgReq.data;
                REG_CTRL: cfg.run     <= cfgReq.data[0];    // Upper bits are ignored
                default:  cfg         <= cfg;
            endcase
        end
    end

endmodule

//--- hw/txDriver.sv
/*
 * Transmit sequencer for the beacon.
 * Walks the ROM from address 0 to msgLen-1, offers each byte to the
 * serializer, waits for the last frame, pulses msgDone and then idles
 * for the programmed gap before it looks at the run bit again.
 */
module txDriver
    import uartPkg::*;
(
    input  logic              Enable,
    input  logic              arstN,
    input  txCfg_t            cfg,
    output logic              rdEn,
    output logic [ADDR_W-1:0] addr,
    input  logic [7:0]        rdData,
    output logic              byteValid,
    input  logic              byteReady,
    output txByte_t           byteData,
    input  logic              frameDone,
    output logic              busy,
    output logic              msgDone
);

    typedef enum logic [2:0] {
        stIdle,     // Waiting for run
        stFetch,    // ROM read in flight
        stOffer,    // Byte held on the handshake
        stDrain,    // Last frame still on the line
        stGap       // Counting idle cycles between messages
    } drvState_t;

    drvState_t   state;
    logic [15:0] gapCnt;
    logic        lastAddr;

    // Current address is the final one of this message
    assign lastAddr = ({1'b0, addr} == cfg.msgLen - 1'b1);

    // Settings are locked from the first fetch until the last stop bit
    assign busy = (state == stFetch) || (state == stOffer) || (state == stDrain);

    always_ff @(posedge Enable or negedge arstN) begin
        if (!arstN) begin
            state     <= stIdle;
            rdEn      <= 1'b0;
            addr      <= '0;
            byteValid <= 1'b0;
            msgDone   <= 1'b0;
            gapCnt    <= '0;
        end else begin
            msgDone <= 1'b0;                                // Single cycle pulse
            case (state)
                stIdle: begin
                    if (cfg.run) begin                      // Start a fresh message
                        addr  <= '0;
                        rdEn  <= 1'b1;
                        state <= stFetch;
                    end
                end
                stFetch: begin
                    if (rdEn) begin
                        rdEn <= 1'b0;                       // ROM samples on this edge
                    end else begin
                        byteValid <= 1'b1;                  // Data captured below
                        state     <= stOffer;
                    end
                end
                stOffer: begin
                    if (byteReady) begin                    // Serializer took the byte
                        byteValid <= 1'b0;
                        if (byteData.last) begin
                            state <= stDrain;
                        end else begin
                            addr  <= addr + 1'b1;
                            rdEn  <= 1'b1;
                            state <= stFetch;
                        end
                    end
                end
                stDrain: begin
                    // Earlier frameDone pulses land before the last transfer
                    if (frameDone) begin
                        msgDone <= 1'b1;
                        gapCnt  <= '0;
                        state   <= stGap;
                    end
                end
                stGap: begin
                    if (gapCnt == cfg.gap) state <= stIdle; // Run is checked again in idle
                    else gapCnt <= gapCnt + 1'b1;
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Byte register loads when the ROM word has settled
    always_ff @(posedge Enable) begin
        if (state == stFetch && !rdEn) begin
            byteData.data <= rdData;
            byteData.last <= lastAddr;
        end
    end

endmodule

//--- hw/uartPkg.sv
/*
 * Shared definitions for the ROM message beacon.
 * Holds the message text, the register map, the reset defaults and the
 * structs that carry configuration and bytes between the blocks.
 */
package uartPkg;

    // Message store geometry
    localparam int MSG_LEN = 16;                    // Bytes in the beacon message
    localparam int ADDR_W  = 4;                     // ROM address width
    localparam int LEN_W   = ADDR_W + 1;            // Wide enough to hold MSG_LEN itself

    // First character sent sits in the top byte of the literal
    localparam logic [8*MSG_LEN-1:0] MSG_TEXT = "Hello, beacon!\r\n";

    localparam logic [LEN_W-1:0] LEN_MAX = LEN_W'(MSG_LEN);    // Longest legal message

    // Serial timing defaults, all in clock cycles
    localparam logic [15:0] BAUD_DIV_RESET = 16'd8;     // Cycles per bit after reset
    localparam logic [15:0] BAUD_DIV_MIN   = 16'd2;     // Shortest bit the serializer handles
    localparam logic [15:0] GAP_RESET      = 16'd64;    // Idle cycles between repetitions

    // Register map of the configuration write port
    localparam logic [1:0] REG_BAUD = 2'd0;
    localparam logic [1:0] REG_LEN  = 2'd1;
    localparam logic [1:0] REG_GAP  = 2'd2;
    localparam logic [1:0] REG_CTRL = 2'd3;             // Bit 0 is the run bit

    // One write request on the configuration port
    typedef struct packed {
        logic [1:0]  addr;
        logic [15:0] data;
    } cfgWrite_t;

    // Live configuration as seen by the driver and the serializer
    typedef struct packed {
        logic [15:0]      baudDiv;   // Cycles per bit, never below BAUD_DIV_MIN
        logic [LEN_W-1:0] msgLen;    // Bytes per message, 1 to MSG_LEN
        logic [15:0]      gap;       // Idle cycles after msgDone
        logic             run;       // Keep repeating while set
    } txCfg_t;

    // Byte offered to the serializer
    typedef struct packed {
        logic [7:0] data;
        logic       last;            // Marks the final byte of a message
    } txByte_t;

    localparam txCfg_t CFG_RESET = '{
        baudDiv: BAUD_DIV_RESET,
        msgLen:  LEN_MAX,
        gap:     GAP_RESET,
        run:     1'b0
    };

endpackage

//--- hw/uartTx.sv
/*
 * 8N1 UART serializer.
 * Accepts one byte over valid/ready while idle, then drives a start
 * bit, eight data bits LSB first and a stop bit, each baudDiv cycles
 * long, and pulses frameDone as the stop bit ends.
 */
module uartTx
    import uartPkg::*;
(
    input  logic        Enable,
    input  logic        arstN,
    input  logic [15:0] baudDiv,      // Cycles per bit, at least 2
    input  logic        byteValid,
    output logic        byteReady,
    input  txByte_t     byteData,
    output logic        txd,
    output logic        frameDone
);

    logic        sending;     // A frame is on the line
    logic [8:0]  shiftReg;    // Data bits with the stop bit behind them
    logic [3:0]  bitCnt;      // 0 is start, 1 to 8 data, 9 stop
    logic [15:0] baudCnt;
    logic        bitEnd;
    logic        accept;

    assign byteReady = !sending;
    assign accept    = byteValid && !sending;
    assign bitEnd    = (baudCnt == baudDiv - 16'd1);    // Last cycle of the current bit

    always_ff @(posedge Enable or negedge arstN) begin
        if (!arstN) begin
            sending   <= 1'b0;
            txd       <= 1'b1;                          // Line idles high
            bitCnt    <= '0;
            baudCnt   <= '0;
            frameDone <= 1'b0;
        end else begin
            frameDone <= 1'b0;
            if (accept) begin
                sending <= 1'b1;
                txd     <= 1'b0;                        // Start bit from the next cycle on
                bitCnt  <= '0;
                baudCnt <= '0;
            end else if (sending) begin
                if (bitEnd) begin
                    baudCnt <= '0;
                    if (bitCnt == 4'd9) begin
                        sending   <= 1'b0;              // Stop bit done, ready again
                        frameDone <= 1'b1;
                    end else begin
                        txd    <= shiftReg[0];          // Data LSB first, then stop
                        bitCnt <= bitCnt + 1'b1;
                    end
                end else begin
                    baudCnt <= baudCnt + 1'b1;
                end
            end
        end
    end

    // Ones shift in behind the data so the line stays high after stop
    always_ff @(posedge Enable) begin
        if (accept) begin
            shiftReg <= {1'b1, byteData.data};
        end else if (sending && bitEnd) begin
            shiftReg <= {1'b1, shiftReg[8:1]};
        end
    end

endmodule

//--- romUartTx.f
hw/uartPkg.sv
hw/messageRom.sv
hw/uartTx.sv
hw/txDriver.sv
hw/txConfig.sv
hw/romUartTop.sv
sim/romUartTop_sva.sv
sim/romUartChecker.sv
sim/romUartTb.sv

//--- sim/romUartChecker.sv
/*
 * Serial line checker for the ROM message beacon.
 * Decodes 8N1 frames from txd and compares each byte and its bit timing
 * with the message text. Also watches msgDone, the gap and the write port.
 */
module romUartChecker
    import uartPkg::*;
(
    input  logic Enable,
    input  logic arstN,
    input  logic txd,
    input  logic msgDone,
    input  logic cfgValid,
    input  logic cfgReady,
    input  int   baudDiv,       // Last divisor written by the testbench
    input  int   msgLen,        // Last length written, already clamped
    input  int   gap,
    input  logic quiet,         // High while the line must stay idle
    output int   dataErrs,
    output int   otherErrs,
    output int   frameCount,
    output int   msgCount
);
    timeunit 1ns;
    timeprecision 100ps;

    int   frameErrs;            // Plain word failures seen by the decoder
    int   watchErrs;            // Plain word failures seen by the monitor
    int   framesAtDone;         // frameCount at the most recent msgDone
    int   cycle;
    int   lastDoneCycle;
    logic txdPrev;
    logic quietPrev;
    logic inMsg;

    assign otherErrs = frameErrs + watchErrs;

    // Reference byte at one position of the message
    function automatic logic [7:0] expectedByte(input int index);
        logic [8*MSG_LEN-1:0] shifted;
        shifted = MSG_TEXT >> (8 * (MSG_LEN - 1 - index));     // Byte 0 is the top of the text
        return shifted[7:0];
    endfunction

    // Line stays low for the start bit plus every zero below the first one
    function automatic int expectedLowRun(input logic [7:0] data, input int div);
        logic [7:0] rest;
        int         run;
        int         n;
        rest = data;
        run  = div;
        for (n = 0; n < 8; n++) begin
            if (rest[0] === 1'b1) return run;
            run  = run + div;
            rest = rest >> 1;
        end
        return run;
    endfunction

    // Called on the first low sample and returns at the middle of the stop bit
    task automatic decodeFrame();
        int         div;
        int         idx;
        int         lowRun;
        int         last;
        int         c;
        logic       stillLow;
        logic [9:0] frameBits;
        logic [7:0] dataByte;
        div       = baudDiv;
        idx       = frameCount - framesAtDone;
        lowRun    = 0;
        stillLow  = 1'b1;
        frameBits = '0;
        last      = 9 * div + div / 2;
        for (c = 0; c <= last; c++) begin
            if (stillLow && txd === 1'b0) lowRun++;
            else stillLow = 1'b0;
            if (c % div == div / 2) frameBits = {txd, frameBits[9:1]};  // Centre of a bit
            if (c < last) @(negedge Enable);
        end
        dataByte = frameBits[8:1];
        if (frameBits[0] !== 1'b0 || frameBits[9] !== 1'b1) begin
            $display("Framing error at byte %0d: start or stop bit has the wrong level", idx);
            frameErrs++;
        end
        if (idx >= msgLen) begin
            $display("Byte %0d sent after a %0d byte message with no msgDone", idx, msgLen);
            frameErrs++;
        end else begin
            if (dataByte !== expectedByte(idx)) begin
                $display("** Error txd byte %0d: expected 0x%02h, actual 0x%02h",
                         idx, expectedByte(idx), dataByte);
                dataErrs++;
            end
            // Low time follows from the byte that should have been sent
            if (lowRun != expectedLowRun(expectedByte(idx), div)) begin
                $display("** Error txd low time at byte %0d: expected 0x%0h, actual 0x%0h cycles",
                         idx, expectedLowRun(expectedByte(idx), div), lowRun);
                dataErrs++;
            end
        end
        frameCount++;
    endtask

    initial begin : frameLoop
        dataErrs   = 0;
        frameErrs  = 0;
        frameCount = 0;
        forever begin
            @(negedge Enable);
            if (arstN === 1'b1 && txd === 1'b0) decodeFrame();
        end
    end

    // Monitor for msgDone, start edges, idle windows and write handshakes
    always @(negedge Enable) begin
        if (arstN !== 1'b1) begin
            watchErrs     = 0;
            msgCount      = 0;
            framesAtDone  = 0;
            cycle         = 0;
            lastDoneCycle = 0;
            txdPrev       = 1'b1;
            quietPrev     = 1'b0;
            inMsg         = 1'b0;
        end else begin
            cycle++;
            if (msgDone === 1'b1) begin
                if (quiet) begin
                    $display("msgDone pulsed while the beacon should be idle");
                    watchErrs++;
                end
                if (frameCount - framesAtDone != msgLen) begin
                    $display("msgDone after %0d bytes where %0d were expected",
                             frameCount - framesAtDone, msgLen);
                    watchErrs++;
                end
                framesAtDone  = frameCount;
                msgCount++;
                lastDoneCycle = cycle;
                inMsg         = 1'b0;
            end
            if (txdPrev === 1'b1 && txd !== 1'b1) begin         // Start edge
                if (quiet) begin
                    $display("Start bit on txd while the beacon should be idle");
                    watchErrs++;
                end
                if (msgCount > 0 && !inMsg && cycle - lastDoneCycle < gap) begin
                    $display("Next message began %0d cycles after msgDone with a gap of %0d",
                             cycle - lastDoneCycle, gap);
                    watchErrs++;
                end
                inMsg = 1'b1;
            end
            if (quiet && !quietPrev && frameCount != framesAtDone) begin
                $display("Message ended after %0d bytes with no msgDone",
                         frameCount - framesAtDone);
                watchErrs++;
            end
            if (cfgValid === 1'b1 && cfgReady === 1'b1 && inMsg) begin
                $display("Configuration write accepted in the middle of a message");
                watchErrs++;
            end
            txdPrev   = txd;
            quietPrev = quiet;
        end
    end

endmodule

//--- sim/romUartTb.sv
/*
 * Testbench for the ROM message beacon.
 * Drives clock, reset and configuration writes, picks baud divisors and
 * lengths from an LFSR, bounds the run time and prints the closing report.
 */
module romUartTb
    import uartPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic        Enable;
    logic        arstN;
    logic        cfgValid;
    logic        cfgReady;
    cfgWrite_t   cfgReq;
    logic        txd;
    logic        msgDone;
    logic        quiet;                 // Tells the checker that no traffic is allowed
    int          shBaud;                // Copies of what the DUT registers should hold
    int          shLen;
    int          shGap;
    int          dataErrs;
    int          otherErrs;
    int          frameCount;
    int          msgCount;
    int          cycleCount = 0;
    int          cycleLimit;
    logic [15:0] lfsr;
    int          bauds [3];
    int          randLen;

    romUartTop u_dut (
        .Enable(Enable), .arstN(arstN), .cfgValid(cfgValid), .cfgReady(cfgReady),
        .cfgReq(cfgReq), .txd(txd), .msgDone(msgDone)
    );

    romUartChecker u_checker (
        .Enable(Enable), .arstN(arstN), .txd(txd), .msgDone(msgDone),
        .cfgValid(cfgValid), .cfgReady(cfgReady), .baudDiv(shBaud), .msgLen(shLen),
        .gap(shGap), .quiet(quiet), .dataErrs(dataErrs), .otherErrs(otherErrs),
        .frameCount(frameCount), .msgCount(msgCount)
    );

    always #50 Enable = !Enable;        // 100 ns period

    always @(posedge Enable) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: tests still running after %0d cycles", cycleCount);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [15:0] galoisStep(input logic [15:0] s);
        if (s[0]) return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic drawBits(input int n, output int value);
        value = 0;
        repeat (n) begin
            lfsr  = galoisStep(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic int msgCycles(input int len, input int baud, input int gapLen);
        return len * 10 * baud + gapLen;
    endfunction

    // Holds the request until the DUT accepts it, then tracks the clamped value
    task automatic writeReg(input logic [1:0] addr, input int value);
        logic taken;
        taken = 1'b0;
        @(posedge Enable);
        #5;
        cfgValid    = 1'b1;
        cfgReq.addr = addr;
        cfgReq.data = 16'(value);
        while (!taken) begin
            @(negedge Enable);
            taken = cfgReady;           // Stays put until the rising edge
            @(posedge Enable);
        end
        #5;
        cfgValid = 1'b0;
        case (addr)
            REG_BAUD: shBaud = (value < 2) ? 2 : value;
            REG_LEN:  shLen  = (value < 1) ? 1 : ((value > MSG_LEN) ? MSG_LEN : value);
            REG_GAP:  shGap  = value;
            default:  ;
        endcase
    endtask

    task automatic holdQuiet(input int cycles);
        @(posedge Enable);
        #5 quiet = 1'b1;
        repeat (cycles) @(posedge Enable);
        #5 quiet = 1'b0;
    endtask

    // Sends count copies and clears run while the final copy is on the line
    task automatic runMessages(input int count);
        int target;
        target = frameCount + (count - 1) * shLen + 1;
        writeReg(REG_CTRL, 1);
        while (frameCount < target) @(posedge Enable);
        writeReg(REG_CTRL, 0);          // Accepted only once msgDone frees the port
        holdQuiet(2 * shGap);
    endtask

    initial begin
        int i;
        Enable   = 1'b0;
        arstN    = 1'b1;
        cfgValid = 1'b0;
        cfgReq   = '0;
        quiet    = 1'b0;
        shBaud   = int'(BAUD_DIV_RESET);
        shLen    = MSG_LEN;
        shGap    = int'(GAP_RESET);
        lfsr     = 16'd37;
        for (i = 0; i < 3; i++) begin
            drawBits(4, bauds[i]);
            bauds[i] += 2;              // Divisors 2 to 17
        end
        drawBits(4, randLen);
        randLen += 1;                   // Lengths 1 to 16
        cycleLimit = 2 * msgCycles(MSG_LEN, 8, 64) + msgCycles(randLen, 4, 32)
                   + msgCycles(1, 4, 32) + msgCycles(MSG_LEN, 4, 32);
        for (i = 0; i < 3; i++) cycleLimit += msgCycles(MSG_LEN, bauds[i], 64);
        cycleLimit = 2 * cycleLimit + 2000;

        #1 arstN = 1'b0;
        repeat (16) @(posedge Enable);
        #5 arstN = 1'b1;

        holdQuiet(100);                 // Idle line before run is ever set
        runMessages(2);                 // Reset settings, two copies back to back
        for (i = 0; i < 3; i++) begin
            writeReg(REG_BAUD, bauds[i]);
            runMessages(1);
        end
        writeReg(REG_BAUD, 4);
        writeReg(REG_GAP, 32);
        writeReg(REG_LEN, randLen);
        runMessages(1);
        writeReg(REG_LEN, 0);           // Clamps up to one byte
        runMessages(1);
        writeReg(REG_LEN, 20);          // Clamps down to the full text
        runMessages(1);

        $display("Closing report: %0d frames, %0d messages, %0d data errors, %0d other errors",
                 frameCount, msgCount, dataErrs, otherErrs);
        if (dataErrs + otherErrs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sim/romUartTop_sva.sv
/*
 * Concurrent assertions for the beacon top level.
 * Bound into romUartTop and watching its ports.
 */
module romUartTop_sva (
    input logic Enable,
    input logic arstN,
    input logic txd,
    input logic msgDone,
    input logic cfgReady
);
    timeunit 1ns;
    timeprecision 100ps;

    // Serial line rests high while reset is applied
    txdHighInReset: assert property (@(posedge Enable) !arstN |-> txd)
        else $error("txd is not high while arstN is low");

    // Status pulse is exactly one cycle wide
    msgDoneOneCycle: assert property (
        @(posedge Enable) disable iff (!arstN) msgDone |=> !msgDone
    ) else $error("msgDone stayed high for more than one cycle");

    // A low line means a frame is going out, so the driver is busy and writes wait
    cfgLockedWhenBusy: assert property (
        @(posedge Enable) disable iff (!arstN) !txd |-> !cfgReady
    ) else $error("cfgReady is high while a frame is on txd");

endmodule

bind romUartTop romUartTop_sva u_sva (
    .Enable(Enable),
    .arstN(arstN),
    .txd(txd),
    .msgDone(msgDone),
    .cfgReady(cfgReady)
);
